/* rtl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // field widths of a fetch address as the icache slices it
    localparam int ADDR_W   = 32;
    localparam int INST_W   = 32;
    localparam int TAG_W    = 20;  // bits 31..12
    localparam int INDEX_W  = 8;   // bits 11..4, 256 sets
    localparam int OFFSET_W = 4;   // byte in a 16 byte line

    // byte address, always word aligned when it goes out as a request
    typedef logic [ADDR_W-1:0] addr_t;

    // raw instruction word from the icache
    typedef logic [INST_W-1:0] inst_t;

    // icache address fields, high to low
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // requests allowed in flight at once
    localparam int FETCH_DEPTH_DEFAULT = 4;

endpackage

`default_nettype wire

/* rtl/cpu_ctrl_pkg.sv */
`default_nettype none

package cpu_ctrl_pkg;

    // kseg1 boot rom, first fetch after reset
    localparam logic [31:0] RESET_PC   = 32'hbfc0_0000;
    // general exception entry with BEV set
    localparam logic [31:0] EXC_VECTOR = 32'hbfc0_0380;

    // life of one fetch queue slot
    typedef enum logic [1:0] {
        slot_free,   // nothing outstanding
        slot_live,   // response goes to IF
        slot_stale   // redirected away, response gets dropped
    } slot_state_t;

endpackage

`default_nettype wire

/* rtl/pre_if_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module pre_if_stage import fetch_pkg::*, cpu_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    br_taken,
    input  logic    br_stall,
    input  logic    flush,
    input  logic    eret,
    input  addr_t   br_target,
    input  addr_t   cp0_epc,
    input  addr_t   fs_pc,        // last accepted address
    input  logic    fs_allowin,
    input  logic    queue_full,
    input  logic    inst_addr_ok,
    output logic    inst_valid,
    output tag_t    inst_tag,
    output index_t  inst_index,
    output offset_t inst_offset,
    output addr_t   req_pc,
    output logic    redirect,
    output logic    adel_hold
);

    logic  br_go;          // branch that really redirects
    logic  hold_q;         // parked on a misaligned pc
    logic  pend_valid_q;   // redirect seen, target not yet accepted
    addr_t pend_pc_q;
    addr_t redirect_pc;
    addr_t seq_pc;
    logic  misaligned;
    logic  req_accept;

    assign seq_pc = fs_pc + 32'd4;

    // stalled branch has no effect
    // while parked, only flush or eret may move the pc
    assign br_go    = br_taken & ~br_stall & ~hold_q;
    assign redirect = eret | flush | br_go;

    // eret over flush over branch
    always_comb begin
        if (eret) begin
            redirect_pc = cp0_epc;
        end else if (flush) begin
            redirect_pc = EXC_VECTOR;
        end else begin
            redirect_pc = br_target;
        end
    end

    // fresh redirect goes out in its own cycle
    always_comb begin
        if (redirect) begin
            req_pc = redirect_pc;
        end else if (pend_valid_q) begin
            req_pc = pend_pc_q;  // still waiting for addr_ok
        end else begin
            req_pc = seq_pc;
        end
    end

    assign misaligned = req_pc[1:0] != 2'b00;
    assign adel_hold  = misaligned;

    // in reset the queue drops pushes, so nothing may be accepted
    // full IF or full queue would lose the response
    assign inst_valid = ~reset & fs_allowin & ~queue_full & ~misaligned;
    assign req_accept = inst_valid & inst_addr_ok;

    assign {inst_tag, inst_index, inst_offset} = req_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid_q <= 1'b0;
        end else if (req_accept) begin
            pend_valid_q <= 1'b0;  // target is on its way
        end else if (redirect) begin
            pend_valid_q <= 1'b1;
        end
    end

    // target kept until the cache takes it
    always_ff @(posedge clk) begin
        if (redirect && !req_accept) begin
            pend_pc_q <= redirect_pc;
        end
    end

    // clears as soon as flush or eret picks an aligned pc
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_q <= 1'b0;
        end else begin
            hold_q <= misaligned;
        end
    end

    // a misaligned pc never reaches the cache and stays put until an exception path
    assert property (@(posedge clk) disable iff (reset)
        hold_q && !(flush || eret) |-> !inst_valid && adel_hold);

    // an offered address does not move until taken or redirected
    assert property (@(posedge clk) disable iff (reset)
        inst_valid && !inst_addr_ok |=> !inst_valid || redirect || $stable(req_pc));

endmodule

`default_nettype wire

/* rtl/fetch_queue.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_queue import fetch_pkg::*, cpu_ctrl_pkg::*; #(
    parameter int DEPTH = FETCH_DEPTH_DEFAULT  // power of two, 2 or more
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,          // request accepted by the cache
    input  addr_t push_pc,
    input  logic  redirect,
    input  logic  inst_data_ok,
    input  inst_t inst_rdata,
    output logic  full,
    output addr_t last_pc,
    output logic  resp_valid,
    output addr_t resp_pc,
    output inst_t resp_inst
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    addr_t            slot_pc [DEPTH];   // address of each request
    slot_state_t      slot_st [DEPTH];
    logic [PTR_W-1:0] head_q;            // oldest outstanding
    logic [PTR_W-1:0] tail_q;            // next free slot
    logic [CNT_W-1:0] count_q;
    addr_t            last_pc_q;
    logic             empty;
    logic             pop;
    logic             head_live;

    assign empty = count_q == '0;
    assign full  = count_q == FULL_CNT;

    // responses come back in order, so every data_ok retires the head
    assign pop       = inst_data_ok;
    assign head_live = slot_st[head_q] == slot_live;

    // same cycle pass through
    // the head turns stale in a redirect cycle, so it is dropped there too
    assign resp_valid = inst_data_ok & head_live & ~redirect;
    assign resp_pc    = slot_pc[head_q];
    assign resp_inst  = inst_rdata;
    assign last_pc    = last_pc_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                slot_st[i] <= slot_free;
            end
        end else begin
            // everything in flight is wrong path now
            for (int i = 0; i < DEPTH; i++) begin
                if (redirect && slot_st[i] == slot_live) begin
                    slot_st[i] <= slot_stale;
                end
            end
            if (pop) begin
                slot_st[head_q] <= slot_free;
            end
            // request issued with the redirect belongs to the new path
            if (push) begin
                slot_st[tail_q] <= slot_live;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slot_pc[tail_q] <= push_pc;
        end
    end

    // pointers wrap on their own
    always_ff @(posedge clk) begin
        if (reset) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (pop) begin
                head_q <= head_q + PTR_W'(1);
            end
            if (push) begin
                tail_q <= tail_q + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q;  // both or neither
            endcase
        end
    end

    // base for the sequential pc, first +4 lands on the reset vector
    always_ff @(posedge clk) begin
        if (reset) begin
            last_pc_q <= RESET_PC - 32'd4;
        end else if (push) begin
            last_pc_q <= push_pc;
        end
    end

    // the cache answers only what was accepted
    assert property (@(posedge clk) disable iff (reset)
        inst_data_ok |-> !empty);

    // pre-IF must stop issuing once all slots are taken
    assert property (@(posedge clk) disable iff (reset)
        push |-> !full);

endmodule

`default_nettype wire

/* rtl/if_stage.sv */
`default_nettype none
`timescale 1ns/10ps

module if_stage import fetch_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  resp_valid,      // live response from the queue
    input  addr_t resp_pc,
    input  inst_t resp_inst,
    input  logic  redirect,
    input  logic  ds_allowin,
    output logic  fs_allowin,
    output logic  fs_to_ds_valid,
    output addr_t fs_pc_out,
    output inst_t fs_inst
);

    logic  fs_valid;     // entry held for decode
    addr_t fs_pc_q;
    inst_t fs_inst_q;

    // room when empty or when decode takes the entry this cycle
    assign fs_allowin = ~fs_valid | ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (resp_valid) begin
            fs_valid <= 1'b1;  // new word replaces the one decode takes
        end else if (redirect || ds_allowin) begin
            // taken by decode, or a stalled wrong path entry
            fs_valid <= 1'b0;
        end
    end

    // pc and word stay paired
    always_ff @(posedge clk) begin
        if (resp_valid) begin
            fs_pc_q   <= resp_pc;
            fs_inst_q <= resp_inst;
        end
    end

    assign fs_to_ds_valid = fs_valid;
    assign fs_pc_out      = fs_pc_q;
    assign fs_inst        = fs_inst_q;

    // queue drops the redirect cycle response, so decode sees no wrong path word
    assert property (@(posedge clk) disable iff (reset)
        redirect |=> !fs_to_ds_valid);

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; #(
    parameter int DEPTH = FETCH_DEPTH_DEFAULT  // outstanding icache reads
) (
    input  logic    clk,
    input  logic    reset,
    // from decode
    input  logic    br_taken,
    input  logic    br_stall,
    input  addr_t   br_target,
    input  logic    ds_allowin,
    // from writeback and cp0
    input  logic    flush,
    input  logic    eret,
    input  addr_t   cp0_epc,
    // icache request port
    output logic    inst_valid,
    output tag_t    inst_tag,
    output index_t  inst_index,
    output offset_t inst_offset,
    input  logic    inst_addr_ok,
    input  logic    inst_data_ok,
    input  inst_t   inst_rdata,
    // to decode
    output logic    fs_to_ds_valid,
    output addr_t   fs_pc_out,
    output inst_t   fs_inst,
    output logic    fs_adel_hold
);

    logic  fs_allowin;
    logic  queue_full;
    logic  redirect;
    logic  req_fire;      // addr handshake done
    addr_t req_pc;
    addr_t last_pc;
    logic  resp_valid;
    addr_t resp_pc;
    inst_t resp_inst;

    assign req_fire = inst_valid & inst_addr_ok;

    pre_if_stage u_pre_if_stage (
        .clk          (clk),
        .reset        (reset),
        .br_taken     (br_taken),
        .br_stall     (br_stall),
        .flush        (flush),
        .eret         (eret),
        .br_target    (br_target),
        .cp0_epc      (cp0_epc),
        .fs_pc        (last_pc),
        .fs_allowin   (fs_allowin),
        .queue_full   (queue_full),
        .inst_addr_ok (inst_addr_ok),
        .inst_valid   (inst_valid),
        .inst_tag     (inst_tag),
        .inst_index   (inst_index),
        .inst_offset  (inst_offset),
        .req_pc       (req_pc),
        .redirect     (redirect),
        .adel_hold    (fs_adel_hold)
    );

    fetch_queue #(
        .DEPTH (DEPTH)
    ) u_fetch_queue (
        .clk          (clk),
        .reset        (reset),
        .push         (req_fire),
        .push_pc      (req_pc),
        .redirect     (redirect),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .full         (queue_full),
        .last_pc      (last_pc),
        .resp_valid   (resp_valid),
        .resp_pc      (resp_pc),
        .resp_inst    (resp_inst)
    );

    if_stage u_if_stage (
        .clk            (clk),
        .reset          (reset),
        .resp_valid     (resp_valid),
        .resp_pc        (resp_pc),
        .resp_inst      (resp_inst),
        .redirect       (redirect),
        .ds_allowin     (ds_allowin),
        .fs_allowin     (fs_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc_out      (fs_pc_out),
        .fs_inst        (fs_inst)
    );

endmodule

`default_nettype wire

/* testbench/fetch_unit_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module fetch_unit_tb import fetch_pkg::*; ();

    localparam addr_t BOOT_PC        = 32'hbfc0_0000;
    localparam addr_t EXC_PC         = 32'hbfc0_0380;
    localparam addr_t DECOY_PC       = 32'h8000_7770;  // branch that must lose or be ignored
    localparam int    TIMEOUT_CYCLES = 2000;
    localparam int    HOLD_CYCLES    = 6;
    localparam int    NUM_ROWS       = 11;

    typedef enum logic [2:0] {
        ev_none,
        ev_branch,
        ev_stalled,   // taken but stalled, no effect
        ev_flush,
        ev_eret
    } ev_t;

    typedef struct packed {
        ev_t         ev;
        addr_t       target;  // br_target or cp0_epc
        logic [7:0]  count;   // instructions decode must take afterwards
    } row_t;

    localparam row_t ROWS [NUM_ROWS] = '{
        '{ev_none,    32'h0000_0000, 8'd12},  // boot path
        '{ev_branch,  32'h8000_1000, 8'd10},
        '{ev_stalled, 32'h8000_5000, 8'd10},
        '{ev_flush,   32'h0000_0000, 8'd8},
        '{ev_eret,    32'h8000_2340, 8'd8},
        '{ev_none,    32'h0000_0000, 8'd40},  // long run under decode stalls
        '{ev_branch,  32'h9fc0_0120, 8'd6},
        '{ev_branch,  32'h8000_3002, 8'd0},   // misaligned, front end parks
        '{ev_flush,   32'h0000_0000, 8'd10},  // way out of the park
        '{ev_eret,    32'hbfc0_1ffc, 8'd12},
        '{ev_branch,  32'h8000_0ff8, 8'd16}   // walks across a tag boundary
    };

    logic    clk          = 1'b0;
    logic    reset        = 1'b1;
    logic    br_taken     = 1'b0;
    logic    br_stall     = 1'b0;
    addr_t   br_target    = '0;
    logic    ds_allowin   = 1'b1;
    logic    flush        = 1'b0;
    logic    eret         = 1'b0;
    addr_t   cp0_epc      = '0;
    logic    inst_addr_ok = 1'b0;
    logic    inst_data_ok = 1'b0;
    inst_t   inst_rdata   = '0;
    logic    inst_valid;
    tag_t    inst_tag;
    index_t  inst_index;
    offset_t inst_offset;
    logic    fs_to_ds_valid;
    addr_t   fs_pc_out;
    inst_t   fs_inst;
    logic    fs_adel_hold;

    addr_t       exp_pc     = BOOT_PC;  // next address decode should get
    int          xfer_count = 0;
    logic [31:0] rng        = 32'habd94bf5;
    int          edge_no    = 0;
    int          stall_left = 0;
    logic        draining   = 1'b0;
    addr_t       req_addr_q [$];        // cache requests in flight
    int          req_due_q  [$];        // edge at which data_ok goes out

    always #10 clk = ~clk;

    fetch_unit #(
        .DEPTH (FETCH_DEPTH_DEFAULT)
    ) u_fetch_unit (
        .clk            (clk),
        .reset          (reset),
        .br_taken       (br_taken),
        .br_stall       (br_stall),
        .br_target      (br_target),
        .ds_allowin     (ds_allowin),
        .flush          (flush),
        .eret           (eret),
        .cp0_epc        (cp0_epc),
        .inst_valid     (inst_valid),
        .inst_tag       (inst_tag),
        .inst_index     (inst_index),
        .inst_offset    (inst_offset),
        .inst_addr_ok   (inst_addr_ok),
        .inst_data_ok   (inst_data_ok),
        .inst_rdata     (inst_rdata),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc_out      (fs_pc_out),
        .fs_inst        (fs_inst),
        .fs_adel_hold   (fs_adel_hold)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_run($sformatf("Error at %0t ns: %s is %h, expected %h",
                               $time, what, actual, expected));
        end
    endtask

    // icache stand-in, in order, 1 to 3 cycles per read
    always @(posedge clk) begin : cache_model
        int   delay;
        logic sending;
        edge_no = edge_no + 1;
        sending = 1'b0;
        if (reset) begin
            req_addr_q.delete();
            req_due_q.delete();
            inst_data_ok <= 1'b0;
            inst_addr_ok <= 1'b0;
            ds_allowin   <= 1'b1;
        end else begin
            if (inst_valid && inst_addr_ok) begin
                rng   = lcg_next(rng);
                delay = 1 + int'(rng[31:28]) % 3;
                req_addr_q.push_back({inst_tag, inst_index, inst_offset});
                req_due_q.push_back(edge_no + delay - 1);
            end
            if (req_due_q.size() != 0 && req_due_q[0] <= edge_no) begin
                inst_data_ok <= 1'b1;
                inst_rdata   <= ~req_addr_q.pop_front();  // word is the inverted address
                void'(req_due_q.pop_front());
                sending = 1'b1;
            end else begin
                inst_data_ok <= 1'b0;
            end
            rng = lcg_next(rng);
            if (stall_left > 0) begin
                stall_left   = stall_left - 1;
                ds_allowin   <= 1'b0;
                inst_addr_ok <= 1'b0;
            end else if (draining) begin
                // decode stalls once nothing is in flight, one IF entry holds one word
                inst_addr_ok <= 1'b0;
                if (req_due_q.size() == 0 && !sending) begin
                    draining   = 1'b0;
                    stall_left = int'(rng[27:26]);  // 1 to 4 cycles low in total
                    ds_allowin <= 1'b0;
                end else begin
                    ds_allowin <= 1'b1;
                end
            end else if (rng[31:29] == 3'b000) begin
                draining     = 1'b1;
                inst_addr_ok <= 1'b0;
                ds_allowin   <= 1'b1;
            end else begin
                ds_allowin   <= 1'b1;
                inst_addr_ok <= rng[24:23] != 2'b00;  // about 3 in 4
            end
        end
    end

    // reference pc model and transfer checks
    always @(posedge clk) begin : pc_model
        if (reset) begin
            check_value(32'(inst_valid), 32'd0, "inst_valid during reset");
        end else begin
            if (inst_valid) begin
                check_value(32'(inst_offset[1:0]), 32'd0, "request address low bits");
            end
            if (fs_to_ds_valid && ds_allowin) begin
                check_value(fs_pc_out, exp_pc, "fs_pc_out");
                check_value(fs_inst, ~exp_pc, "fs_inst");
                exp_pc     = exp_pc + 32'd4;
                xfer_count <= xfer_count + 1;
            end
            // eret over flush over an unstalled branch
            if (eret) begin
                exp_pc = cp0_epc;
            end else if (flush) begin
                exp_pc = EXC_PC;
            end else if (br_taken && !br_stall && exp_pc[1:0] == 2'b00) begin
                exp_pc = br_target;  // parked front end ignores branches
            end
        end
    end

    task automatic wait_transfers(input int goal);
        int cycles;
        cycles = 0;
        while (xfer_count < goal) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run($sformatf("decode got %0d of %0d instructions before the timeout",
                                   xfer_count, goal));
            end
        end
    endtask

    task automatic observe_hold();
        int cycles;
        cycles = 0;
        while (!fs_adel_hold) begin
            @(posedge clk);
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                stop_run("fs_adel_hold never rose after a misaligned branch target");
            end
        end
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(posedge clk);
            check_value(32'(fs_adel_hold), 32'd1, "fs_adel_hold while parked");
            check_value(32'(inst_valid), 32'd0, "inst_valid while parked");
            if (i == 1) begin
                br_taken  <= 1'b1;  // aligned branch, still parked afterwards
                br_target <= DECOY_PC;
            end else begin
                br_taken <= 1'b0;
            end
        end
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        int   base;
        row = ROWS[idx];
        @(posedge clk);
        case (row.ev)
            ev_branch: begin
                br_taken  <= 1'b1;
                br_target <= row.target;
            end
            ev_stalled: begin
                br_taken  <= 1'b1;
                br_stall  <= 1'b1;
                br_target <= row.target;
            end
            ev_flush: begin
                flush     <= 1'b1;
                br_taken  <= 1'b1;  // same cycle branch loses
                br_target <= DECOY_PC;
            end
            ev_eret: begin
                eret      <= 1'b1;
                cp0_epc   <= row.target;
                br_taken  <= 1'b1;
                br_target <= DECOY_PC;
            end
            default: begin
            end
        endcase
        @(posedge clk);  // DUT sees the pulse here
        br_taken <= 1'b0;
        br_stall <= 1'b0;
        flush    <= 1'b0;
        eret     <= 1'b0;
        base = xfer_count;
        if (row.ev == ev_branch && row.target[1:0] != 2'b00) begin
            observe_hold();
        end
        wait_transfers(base + int'(row.count));
    endtask

    initial begin
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/fetch_pkg.sv
rtl/cpu_ctrl_pkg.sv
rtl/pre_if_stage.sv
rtl/fetch_queue.sv
rtl/if_stage.sv
rtl/fetch_unit.sv
testbench/fetch_unit_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
    --top-module fetch_unit_tb \
    -f sources.f \
    -o fetch_unit_sim
./obj_dir/fetch_unit_sim
